//--- Bender.yml
package:
  name: spi_cmd_rx

sources:
  - include_dirs:
      - include
    files:
      - source/spi_cmd_pkg.sv
      - source/resp_if.sv
      - source/frame_gate.sv
      - source/cmd_decoder.sv
      - source/buffer_allocator.sv
      - source/response_serializer.sv
      - source/spi_cmd_rx.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/spi_cmd_rx_tb.sv

//--- dv/spi_cmd_rx_input.txt
# columns: opcode count fill exp_id exp_base exp_status, all hex
# payload nibble = random nibble xor fill, exp_id is the id in the reply
1 003 0 00 00 0
2 004 3 00 00 0
2 002 a 01 04 0
2 005 f 02 06 0
3 000 0 00 00 1
1 000 0 00 00 4
1 028 0 00 00 3
1 020 6 01 03 0
1 01e 0 00 00 2
1 01d 9 02 23 0
1 001 0 00 00 2
2 003 c 03 0b 0
4 000 0 00 00 1
5 000 0 00 00 0
1 002 5 00 00 0
2 001 2 00 00 0

//--- dv/spi_cmd_rx_tb.sv
`default_nettype none

`include "spi_cmd_config.svh"

module spi_cmd_rx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import spi_cmd_pkg::*;

    localparam int VTX_NIBS   = `VTX_W / `NIB_W;
    localparam int TRI_NIBS   = `TRI_W / `NIB_W;
    localparam int WAIT_LIMIT = 64;
    // negedges from the last drive edge to the first reply nibble
    localparam int REPLY_LAT  = `TURN_CYCLES + 3;

    logic                    sck;
    logic                    rst;
    logic                    cs_n;
    logic [`NIB_W-1:0]       spi_in;
    logic [`NIB_W-1:0]       spi_out;
    logic                    spi_oe;
    logic                    opcode_valid;
    opcode_e                 opcode;
    logic                    vert_hdr_valid;
    logic                    tri_hdr_valid;
    logic [`ID_W-1:0]        hdr_id;
    logic [`VERT_ADDR_W-1:0] hdr_base;
    logic [`CNT_W-1:0]       hdr_count;
    logic                    vert_valid;
    vertex_t                 vert_data;
    logic                    tri_valid;
    tri_t                    tri_data;
    logic                    soft_reset;

    integer       seed = 32'h434f_6c7e;
    int           error_count = 0;
    int           check_count = 0;
    int           cmd_count = 0;
    bit           timed_out = 1'b0;

    // expectations for the command in flight
    logic [3:0]   exp_op;
    logic         exp_tri_kind;
    logic [31:0]  exp_hdr_id;
    logic [31:0]  exp_hdr_base;
    logic [31:0]  exp_hdr_count;
    logic [127:0] exp_vert_q [$];
    logic [127:0] exp_tri_q [$];
    logic [3:0]   reply_q [$];
    int           opc_pulses;
    int           hdr_pulses;
    int           vert_pulses;
    int           tri_pulses;
    int           wipe_pulses;

    spi_cmd_rx dut_i (
        .sck            (sck),
        .rst            (rst),
        .cs_n           (cs_n),
        .spi_in         (spi_in),
        .spi_out        (spi_out),
        .spi_oe         (spi_oe),
        .opcode_valid   (opcode_valid),
        .opcode         (opcode),
        .vert_hdr_valid (vert_hdr_valid),
        .tri_hdr_valid  (tri_hdr_valid),
        .hdr_id         (hdr_id),
        .hdr_base       (hdr_base),
        .hdr_count      (hdr_count),
        .vert_valid     (vert_valid),
        .vert_data      (vert_data),
        .tri_valid      (tri_valid),
        .tri_data       (tri_data),
        .soft_reset     (soft_reset)
    );

    initial begin
        sck = 1'b0;
        forever #20 sck = ~sck;
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    // outputs settle after the rising edge so sample on the falling one
    always @(negedge sck) begin
        if (!rst) begin
            if (opcode_valid) begin
                opc_pulses++;
                check_value("opcode", opcode, exp_op);
            end
            if (vert_hdr_valid || tri_hdr_valid) begin
                hdr_pulses++;
                check_value("tri_hdr_valid", tri_hdr_valid, exp_tri_kind);
                check_value("vert_hdr_valid", vert_hdr_valid, !exp_tri_kind);
                check_value("hdr_id", hdr_id, exp_hdr_id);
                check_value("hdr_base", hdr_base, exp_hdr_base);
                check_value("hdr_count", hdr_count, exp_hdr_count);
            end
            if (vert_valid) begin
                vert_pulses++;
                if (exp_vert_q.size() == 0) begin
                    error_count++;
                    $display("vert_valid pulsed with no vertex record pending");
                end else begin
                    check_value("vert_data", vert_data, exp_vert_q.pop_front());
                end
            end
            if (tri_valid) begin
                tri_pulses++;
                if (exp_tri_q.size() == 0) begin
                    error_count++;
                    $display("tri_valid pulsed with no triangle record pending");
                end else begin
                    check_value("tri_data", tri_data, exp_tri_q.pop_front());
                end
            end
            if (soft_reset)
                wipe_pulses++;
            if (spi_oe)
                reply_q.push_back(spi_out);
        end
    end

    task automatic drive_nibble(input logic [3:0] v);
        @(posedge sck);
        cs_n   <= 1'b0;
        spi_in <= v;
    endtask

    task automatic send_junk();
        logic [31:0] rnd;
        int          i;
        for (i = 0; i < `SETTLE_CYCLES; i++) begin
            rnd = $random(seed);
            if (i == 2)
                drive_nibble(4'h1);  // looks like create vertex
            else if (i == 5)
                drive_nibble(4'h5);  // looks like wipe
            else
                drive_nibble(rnd[3:0]);
        end
    endtask

    task automatic close_frame();
        @(posedge sck);
        cs_n   <= 1'b1;
        spi_in <= '0;
        repeat (3) @(posedge sck);
    endtask

    task automatic wait_for_oe(input logic level, output int cycles);
        bit done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge sck);
            cycles++;
            if (spi_oe === level)
                done = 1'b1;
        end
        if (!done) begin
            error_count++;
            timed_out = 1'b1;
            $display("timeout: spi_oe did not reach %0b within %0d cycles", level, WAIT_LIMIT);
        end
    endtask

    task automatic run_command(input logic [31:0] op, input logic [31:0] cnt,
                               input logic [31:0] fill, input logic [31:0] exp_id,
                               input logic [31:0] exp_base, input logic [31:0] exp_status);
        logic [3:0]   nibs [$];
        logic [127:0] rec;
        logic [31:0]  rnd;
        logic [3:0]   v;
        int           rec_nibs;
        int           latency;
        int           tail;
        int           r;
        int           i;
        bit           granted;
        granted       = (op == 1 || op == 2) && exp_status == 0;
        exp_op        = op[3:0];
        exp_tri_kind  = op == 2;
        exp_hdr_id    = exp_id;
        exp_hdr_base  = exp_base;
        exp_hdr_count = cnt[`CNT_W-1:0];
        opc_pulses    = 0;
        hdr_pulses    = 0;
        vert_pulses   = 0;
        tri_pulses    = 0;
        wipe_pulses   = 0;
        reply_q.delete();
        exp_vert_q.delete();
        exp_tri_q.delete();
        rec_nibs = (op == 2) ? TRI_NIBS : VTX_NIBS;

        send_junk();
        drive_nibble(op[3:0]);
        if (op == 1 || op == 2) begin
            drive_nibble(cnt[11:8]);  // count goes msb first
            drive_nibble(cnt[7:4]);
            drive_nibble(cnt[3:0]);
        end
        if (granted) begin
            for (r = 0; r < cnt; r++) begin
                nibs.delete();
                rec = '0;
                for (i = 0; i < rec_nibs; i++) begin
                    rnd = $random(seed);
                    v   = rnd[3:0] ^ fill[3:0];
                    nibs.push_back(v);
                    rec = (rec << 4) | v;  // first nibble ends up on top
                end
                if (op == 2)
                    exp_tri_q.push_back(rec);
                else
                    exp_vert_q.push_back(rec);
                for (i = 0; i < rec_nibs; i++)
                    drive_nibble(nibs[i]);
            end
        end

        wait_for_oe(1'b1, latency);
        if (timed_out)
            return;
        wait_for_oe(1'b0, tail);
        if (timed_out)
            return;
        close_frame();

        check_value("spi_oe latency", latency, REPLY_LAT);
        check_value("spi_oe high cycles", tail, 3);
        check_value("spi_out nibble count", reply_q.size(), 3);
        if (reply_q.size() == 3) begin
            check_value("spi_out id high", reply_q[0], exp_id[7:4]);
            check_value("spi_out id low", reply_q[1], exp_id[3:0]);
            check_value("spi_out status", reply_q[2], exp_status[3:0]);
        end
        check_value("opcode_valid pulses", opc_pulses, op == 1 || op == 2 || op == 5);
        check_value("hdr_valid pulses", hdr_pulses, granted);
        check_value("vert_valid pulses", vert_pulses, (granted && op == 1) ? cnt : 0);
        check_value("tri_valid pulses", tri_pulses, (granted && op == 2) ? cnt : 0);
        check_value("soft_reset pulses", wipe_pulses, op == 5);
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_cnt;
        logic [31:0] f_fill;
        logic [31:0] f_id;
        logic [31:0] f_base;
        logic [31:0] f_status;
        rst    = 1'b1;
        cs_n   = 1'b1;
        spi_in = '0;
        repeat (2) @(posedge sck);
        rst <= 1'b0;
        @(negedge sck);
        check_value("spi_oe", spi_oe, 0);
        check_value("opcode_valid", opcode_valid, 0);
        check_value("vert_hdr_valid", vert_hdr_valid, 0);
        check_value("tri_hdr_valid", tri_hdr_valid, 0);
        check_value("vert_valid", vert_valid, 0);
        check_value("tri_valid", tri_valid, 0);
        check_value("soft_reset", soft_reset, 0);
        repeat (2) @(posedge sck);

        fd = $fopen("dv/spi_cmd_rx_input.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("could not open the stimulus file dv/spi_cmd_rx_input.txt");
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h",
                            f_op, f_cnt, f_fill, f_id, f_base, f_status);
                if (n == 6) begin  // comment and blank lines fall through
                    run_command(f_op, f_cnt, f_fill, f_id, f_base, f_status);
                    cmd_count++;
                end
            end
            $fclose(fd);
        end
        if (cmd_count == 0) begin
            error_count++;
            $display("no commands were read from the stimulus file");
        end

        $display("commands: %0d, checks: %0d, errors: %0d", cmd_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- include/spi_cmd_config.svh
`ifndef SPI_CMD_CONFIG_SVH
`define SPI_CMD_CONFIG_SVH

// bus and record widths
`define NIB_W           4
`define VTX_W           108
`define TRI_W           36
`define CNT_W           12
`define ID_W            8

// small on purpose so overflow is reachable
`define VERT_MEM_DEPTH  64
`define TRI_MEM_DEPTH   64
`define VERT_ADDR_W     6
`define TRI_ADDR_W      6
`define MAX_BUF_CNT     32

// frame timing in sck edges
`define SETTLE_CYCLES   8
`define TURN_CYCLES     2

`endif

//--- source/buffer_allocator.sv
`default_nettype none

`include "spi_cmd_config.svh"

module buffer_allocator (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    alloc_req,
    input  spi_cmd_pkg::buf_kind_e  alloc_kind,
    input  logic [`CNT_W-1:0]       alloc_count,
    input  logic                    wipe,
    output spi_cmd_pkg::status_e    alloc_status,
    output logic [`ID_W-1:0]        alloc_id,
    output logic [`VERT_ADDR_W-1:0] alloc_base
);
    import spi_cmd_pkg::*;

    localparam int SUM_W = `CNT_W + 1;

    logic [`ID_W-1:0]       vert_id;
    logic [`ID_W-1:0]       tri_id;
    logic [`VERT_ADDR_W:0]  vert_fill;  // one spare bit, full is not empty
    logic [`TRI_ADDR_W:0]   tri_fill;
    logic [SUM_W-1:0]       fill;
    logic [SUM_W-1:0]       depth;
    logic [SUM_W-1:0]       need;
    logic                   grant;

    always_comb begin
        if (alloc_kind == KIND_TRI) begin
            alloc_id = tri_id;
            fill     = SUM_W'(tri_fill);
            depth    = SUM_W'(`TRI_MEM_DEPTH);
        end else begin
            alloc_id = vert_id;
            fill     = SUM_W'(vert_fill);
            depth    = SUM_W'(`VERT_MEM_DEPTH);
        end
        alloc_base = fill[`VERT_ADDR_W-1:0];
        need       = fill + SUM_W'(alloc_count);
        // order of the checks matters
        if (alloc_count == '0)
            alloc_status = EMPTY_BUFFER;
        else if (alloc_count > `CNT_W'(`MAX_BUF_CNT))
            alloc_status = BUFFER_FULL;
        else if (need > depth)
            alloc_status = OUT_OF_MEMORY;
        else
            alloc_status = OK;
    end

    assign grant = alloc_req && alloc_status == OK;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            vert_id   <= '0;
            tri_id    <= '0;
            vert_fill <= '0;
            tri_fill  <= '0;
        end else if (wipe) begin
            vert_id   <= '0;
            tri_id    <= '0;
            vert_fill <= '0;
            tri_fill  <= '0;
        end else if (grant) begin
            if (alloc_kind == KIND_TRI) begin
                tri_id   <= tri_id + 1'b1;
                tri_fill <= need[`TRI_ADDR_W:0];
            end else begin
                vert_id   <= vert_id + 1'b1;
                vert_fill <= need[`VERT_ADDR_W:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/cmd_decoder.sv
`default_nettype none

`include "spi_cmd_config.svh"

module cmd_decoder (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    nib_valid,
    input  logic [`NIB_W-1:0]       nib,
    output logic                    opcode_valid,
    output spi_cmd_pkg::opcode_e    opcode,
    output logic                    alloc_req,
    output spi_cmd_pkg::buf_kind_e  alloc_kind,
    output logic [`CNT_W-1:0]       alloc_count,
    input  spi_cmd_pkg::status_e    alloc_status,
    input  logic [`ID_W-1:0]        alloc_id,
    input  logic [`VERT_ADDR_W-1:0] alloc_base,
    output logic                    vert_hdr_valid,
    output logic                    tri_hdr_valid,
    output logic [`ID_W-1:0]        hdr_id,
    output logic [`VERT_ADDR_W-1:0] hdr_base,
    output logic [`CNT_W-1:0]       hdr_count,
    output logic                    vert_valid,
    output spi_cmd_pkg::vertex_t    vert_data,
    output logic                    tri_valid,
    output spi_cmd_pkg::tri_t       tri_data,
    output logic                    soft_reset,
    output logic                    rearm,
    resp_if.sender                  resp
);
    import spi_cmd_pkg::*;

    localparam int VTX_NIBS = `VTX_W / `NIB_W;
    localparam int TRI_NIBS = `TRI_W / `NIB_W;
    localparam int CNT_NIBS = `CNT_W / `NIB_W;
    localparam int NC_W     = $clog2(VTX_NIBS);

    rx_state_e         state;
    logic [NC_W-1:0]   nib_cnt;   // nibble index within count or record
    logic [NC_W-1:0]   rec_nibs_m1;
    logic [`CNT_W-1:0] rec_cnt;
    logic              busy_q;
    logic              last_cnt_nib;
    logic              rec_end;
    logic              rec_last;

    assign last_cnt_nib = nib_cnt == NC_W'(CNT_NIBS - 1);
    assign rec_nibs_m1  = (state == LOAD_TRI) ? NC_W'(TRI_NIBS - 1) : NC_W'(VTX_NIBS - 1);
    assign rec_end      = nib_cnt == rec_nibs_m1;
    assign rec_last     = rec_cnt == hdr_count - 1'b1;

    // allocator sees the request while the last count nibble is on nib
    assign alloc_req   = nib_valid && state == LOAD_COUNT && last_cnt_nib;
    assign alloc_kind  = (opcode == OP_CREATE_TRI) ? KIND_TRI : KIND_VERT;
    assign alloc_count = {hdr_count[`CNT_W-`NIB_W-1:0], nib};

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            state          <= IDLE_OP;
            nib_cnt        <= '0;
            rec_cnt        <= '0;
            busy_q         <= 1'b0;
            opcode_valid   <= 1'b0;
            vert_hdr_valid <= 1'b0;
            tri_hdr_valid  <= 1'b0;
            vert_valid     <= 1'b0;
            tri_valid      <= 1'b0;
            soft_reset     <= 1'b0;
            rearm          <= 1'b0;
            resp.start     <= 1'b0;
        end else begin
            opcode_valid   <= 1'b0;
            vert_hdr_valid <= 1'b0;
            tri_hdr_valid  <= 1'b0;
            vert_valid     <= 1'b0;
            tri_valid      <= 1'b0;
            soft_reset     <= 1'b0;
            rearm          <= 1'b0;
            resp.start     <= 1'b0;
            busy_q         <= resp.busy;
            case (state)
                IDLE_OP: if (nib_valid) begin
                    nib_cnt <= '0;
                    case (nib)
                        OP_CREATE_VERT, OP_CREATE_TRI: begin
                            opcode_valid <= 1'b1;
                            state        <= LOAD_COUNT;
                        end
                        OP_WIPE_ALL: begin
                            opcode_valid <= 1'b1;
                            soft_reset   <= 1'b1;
                            resp.start   <= 1'b1;
                            state        <= REPLY;
                        end
                        default: begin
                            resp.start <= 1'b1;  // invalid opcode reply
                            state      <= REPLY;
                        end
                    endcase
                end
                LOAD_COUNT: if (nib_valid) begin
                    if (last_cnt_nib) begin
                        nib_cnt <= '0;
                        rec_cnt <= '0;
                        if (alloc_status == OK) begin
                            vert_hdr_valid <= alloc_kind == KIND_VERT;
                            tri_hdr_valid  <= alloc_kind == KIND_TRI;
                            state <= (alloc_kind == KIND_TRI) ? LOAD_TRI : LOAD_VERT;
                        end else begin
                            resp.start <= 1'b1;  // rejected, no payload
                            state      <= REPLY;
                        end
                    end else begin
                        nib_cnt <= nib_cnt + 1'b1;
                    end
                end
                LOAD_VERT, LOAD_TRI: if (nib_valid) begin
                    if (rec_end) begin
                        nib_cnt    <= '0;
                        vert_valid <= state == LOAD_VERT;
                        tri_valid  <= state == LOAD_TRI;
                        if (rec_last) begin
                            resp.start <= 1'b1;
                            state      <= REPLY;
                        end else begin
                            rec_cnt <= rec_cnt + 1'b1;
                        end
                    end else begin
                        nib_cnt <= nib_cnt + 1'b1;
                    end
                end
                REPLY: begin
                    if (rearm)
                        state <= IDLE_OP;  // gate is closed by now
                    else if (busy_q && !resp.busy)
                        rearm <= 1'b1;
                end
                default: state <= IDLE_OP;
            endcase
        end
    end

    always_ff @(posedge sck) begin
        if (nib_valid) begin
            case (state)
                IDLE_OP: begin
                    if (nib inside {OP_CREATE_VERT, OP_CREATE_TRI, OP_WIPE_ALL})
                        opcode <= opcode_e'(nib);
                    resp.id     <= '0;
                    resp.status <= (nib == OP_WIPE_ALL) ? OK : INVALID_OPCODE;
                end
                LOAD_COUNT: begin
                    hdr_count <= alloc_count;
                    if (last_cnt_nib) begin
                        hdr_id      <= alloc_id;
                        hdr_base    <= alloc_base;
                        resp.id     <= '0;
                        resp.status <= alloc_status;
                    end
                end
                LOAD_VERT: vert_data <= {vert_data[`VTX_W-`NIB_W-1:0], nib};
                LOAD_TRI:  tri_data  <= {tri_data[`TRI_W-`NIB_W-1:0], nib};
                default: ;
            endcase
            if ((state == LOAD_VERT || state == LOAD_TRI) && rec_end && rec_last) begin
                resp.id     <= hdr_id;
                resp.status <= OK;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/frame_gate.sv
`default_nettype none

`include "spi_cmd_config.svh"

module frame_gate (
    input  logic              sck,
    input  logic              rst,
    input  logic              cs_n,
    input  logic [`NIB_W-1:0] spi_in,
    input  logic              rearm,
    output logic              nib_valid,
    output logic [`NIB_W-1:0] nib
);

    localparam int SETTLE_W = $clog2(`SETTLE_CYCLES);

    logic [SETTLE_W-1:0] settle_cnt;
    logic                open_q;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            settle_cnt <= '0;
            open_q     <= 1'b0;
            nib_valid  <= 1'b0;
        end else if (cs_n || rearm) begin
            settle_cnt <= '0;  // restart the junk window
            open_q     <= 1'b0;
            nib_valid  <= 1'b0;
        end else if (open_q) begin
            nib_valid <= 1'b1;
        end else begin
            nib_valid <= 1'b0;
            if (settle_cnt == SETTLE_W'(`SETTLE_CYCLES - 1))
                open_q <= 1'b1;
            else
                settle_cnt <= settle_cnt + 1'b1;
        end
    end

    always_ff @(posedge sck) begin
        if (open_q && !cs_n)
            nib <= spi_in;
    end

endmodule

`default_nettype wire

//--- source/resp_if.sv
`default_nettype none

`include "spi_cmd_config.svh"

interface resp_if;
    import spi_cmd_pkg::*;

    logic            start;   // one cycle
    logic [`ID_W-1:0] id;
    status_e         status;
    logic            busy;    // reply in progress

    modport sender (
        output start,
        output id,
        output status,
        input  busy
    );

    modport receiver (
        input  start,
        input  id,
        input  status,
        output busy
    );

endinterface

`default_nettype wire

//--- source/response_serializer.sv
`default_nettype none

`include "spi_cmd_config.svh"

module response_serializer (
    input  logic              sck,
    input  logic              rst,
    resp_if.receiver          resp,
    output logic [`NIB_W-1:0] spi_out,
    output logic              spi_oe
);
    import spi_cmd_pkg::*;

    localparam int STEP_W = $clog2(`TURN_CYCLES + 4);
    localparam logic [STEP_W-1:0] S_ID_HI  = STEP_W'(`TURN_CYCLES);
    localparam logic [STEP_W-1:0] S_ID_LO  = STEP_W'(`TURN_CYCLES + 1);
    localparam logic [STEP_W-1:0] S_STATUS = STEP_W'(`TURN_CYCLES + 2);
    localparam logic [STEP_W-1:0] S_DONE   = STEP_W'(`TURN_CYCLES + 3);

    logic [STEP_W-1:0] step;  // edges since the last command nibble
    logic [`ID_W-1:0]  id_q;
    status_e           status_q;

    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            step      <= '0;
            spi_oe    <= 1'b0;
            resp.busy <= 1'b0;
        end else if (resp.start) begin
            step      <= STEP_W'(2);  // decoder edge plus this one
            resp.busy <= 1'b1;
        end else if (resp.busy) begin
            step <= step + 1'b1;
            if (step == S_ID_HI) begin
                spi_oe <= 1'b1;
            end else if (step == S_DONE) begin
                spi_oe    <= 1'b0;
                resp.busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge sck) begin
        if (resp.start) begin
            id_q     <= resp.id;
            status_q <= resp.status;
        end
        if (resp.busy) begin
            case (step)
                S_ID_HI:  spi_out <= id_q[`ID_W-1:`NIB_W];
                S_ID_LO:  spi_out <= id_q[`NIB_W-1:0];
                S_STATUS: spi_out <= status_q;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/spi_cmd_pkg.sv
`default_nettype none

`include "spi_cmd_config.svh"

package spi_cmd_pkg;

    typedef enum logic [3:0] {
        OP_CREATE_VERT = 4'd1,
        OP_CREATE_TRI  = 4'd2,
        OP_WIPE_ALL    = 4'd5  // 3 and 4 reserved
    } opcode_e;

    typedef enum logic [3:0] {
        OK             = 4'd0,
        INVALID_OPCODE = 4'd1,
        OUT_OF_MEMORY  = 4'd2,
        BUFFER_FULL    = 4'd3,
        EMPTY_BUFFER   = 4'd4
    } status_e;

    typedef enum logic {
        KIND_VERT,
        KIND_TRI
    } buf_kind_e;

    typedef enum logic [2:0] {
        IDLE_OP,
        LOAD_COUNT,
        LOAD_VERT,
        LOAD_TRI,
        REPLY
    } rx_state_e;

    // first nibble on the bus lands in the top bits
    typedef struct packed {
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] z;
        logic [3:0]  attr0;
        logic [3:0]  attr1;
        logic [3:0]  attr2;
    } vertex_t;

    typedef struct packed {
        logic [`CNT_W-1:0] idx0;
        logic [`CNT_W-1:0] idx1;
        logic [`CNT_W-1:0] idx2;
    } tri_t;

endpackage

`default_nettype wire

//--- source/spi_cmd_rx.sv
`default_nettype none

`include "spi_cmd_config.svh"

module spi_cmd_rx (
    input  logic                    sck,
    input  logic                    rst,
    input  logic                    cs_n,
    input  logic [`NIB_W-1:0]       spi_in,
    output logic [`NIB_W-1:0]       spi_out,
    output logic                    spi_oe,
    output logic                    opcode_valid,
    output spi_cmd_pkg::opcode_e    opcode,
    output logic                    vert_hdr_valid,
    output logic                    tri_hdr_valid,
    output logic [`ID_W-1:0]        hdr_id,
    output logic [`VERT_ADDR_W-1:0] hdr_base,
    output logic [`CNT_W-1:0]       hdr_count,
    output logic                    vert_valid,
    output spi_cmd_pkg::vertex_t    vert_data,
    output logic                    tri_valid,
    output spi_cmd_pkg::tri_t       tri_data,
    output logic                    soft_reset
);
    import spi_cmd_pkg::*;

    logic                    nib_valid;
    logic [`NIB_W-1:0]       nib;
    logic                    rearm;
    logic                    alloc_req;
    buf_kind_e               alloc_kind;
    logic [`CNT_W-1:0]       alloc_count;
    status_e                 alloc_status;
    logic [`ID_W-1:0]        alloc_id;
    logic [`VERT_ADDR_W-1:0] alloc_base;

    resp_if resp_i ();

    frame_gate gate_i (
        .sck       (sck),
        .rst       (rst),
        .cs_n      (cs_n),
        .spi_in    (spi_in),
        .rearm     (rearm),
        .nib_valid (nib_valid),
        .nib       (nib)
    );

    cmd_decoder decoder_i (
        .sck            (sck),
        .rst            (rst),
        .nib_valid      (nib_valid),
        .nib            (nib),
        .opcode_valid   (opcode_valid),
        .opcode         (opcode),
        .alloc_req      (alloc_req),
        .alloc_kind     (alloc_kind),
        .alloc_count    (alloc_count),
        .alloc_status   (alloc_status),
        .alloc_id       (alloc_id),
        .alloc_base     (alloc_base),
        .vert_hdr_valid (vert_hdr_valid),
        .tri_hdr_valid  (tri_hdr_valid),
        .hdr_id         (hdr_id),
        .hdr_base       (hdr_base),
        .hdr_count      (hdr_count),
        .vert_valid     (vert_valid),
        .vert_data      (vert_data),
        .tri_valid      (tri_valid),
        .tri_data       (tri_data),
        .soft_reset     (soft_reset),
        .rearm          (rearm),
        .resp           (resp_i.sender)
    );

    buffer_allocator alloc_i (
        .sck          (sck),
        .rst          (rst),
        .alloc_req    (alloc_req),
        .alloc_kind   (alloc_kind),
        .alloc_count  (alloc_count),
        .wipe         (soft_reset),  // wipe all clears ids and bases
        .alloc_status (alloc_status),
        .alloc_id     (alloc_id),
        .alloc_base   (alloc_base)
    );

    response_serializer resp_ser_i (
        .sck     (sck),
        .rst     (rst),
        .resp    (resp_i.receiver),
        .spi_out (spi_out),
        .spi_oe  (spi_oe)
    );

endmodule

`default_nettype wire

//--- spi_cmd_rx.f
+incdir+include
source/spi_cmd_pkg.sv
source/resp_if.sv
source/frame_gate.sv
source/cmd_decoder.sv
source/buffer_allocator.sv
source/response_serializer.sv
source/spi_cmd_rx.sv
dv/spi_cmd_rx_tb.sv
